//--- test/iqe_cases.txt
# op thr wcnt wstart rthr rcnt fetch_stall stall
# thr is the write thread, or the flushed thread for except.
# op is one of write, read, both, except, idle.
write 0 1 0 0 0 0 0
write 0 4 0 0 0 0 1
write 0 3 1 0 0 0 1
write 0 2 2 0 0 0 1
write 0 1 3 0 0 0 1
read 0 0 0 0 2 0 0
read 0 0 0 0 0 0 0
both 0 2 1 0 1 0 0
write 0 4 0 0 0 0 1
write 0 2 0 0 0 0 1
idle 0 0 0 0 0 0 1
write 1 3 0 0 0 0 1
write 1 2 0 0 0 1 1
read 0 0 0 1 1 0 0
read 0 0 0 0 2 0 0
read 0 0 0 0 2 0 0
read 0 0 0 0 2 0 0
both 0 4 0 0 2 0 0
write 0 4 0 0 0 0 1
read 0 0 0 0 2 0 0
read 0 0 0 0 2 0 1
except 0 0 0 0 0 0 0
write 0 2 0 0 0 0 0
read 0 0 0 1 1 0 0
both 1 4 0 1 1 0 0
except 1 0 0 0 0 0 0
read 0 0 0 0 1 0 0
write 1 1 2 1 0 0 0
both 1 1 0 1 1 0 0
both 0 3 1 0 1 0 0
read 0 0 0 0 2 0 0
read 0 0 0 1 1 0 0
write 1 4 0 1 0 0 0
write 1 4 0 1 0 0 1
write 1 4 0 1 0 0 1
write 1 4 0 1 0 0 1
write 1 1 0 1 0 0 1
read 0 0 0 1 2 0 0

//--- tb.f
+incdir+logic
logic/iqe_pkg.sv
logic/iqe_ram_if.sv
logic/iqe_ptr_ctrl.sv
logic/iqe_write_align.sv
logic/iqe_ram.sv
logic/instr_extra_queue.sv
test/tb_instr_extra_queue.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_instr_extra_queue
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_TEXT := ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_instr_extra_queue.sv
// Testbench for the two-thread instruction extra queue.
// Replays the operation list from the case file and checks
// the read outputs and full against a queue reference model.

`timescale 1ns/1ps
`include "iqe_macros.svh"

module tb_instr_extra_queue import iqe_pkg::*; ();

  logic       clk;
  logic       rst;
  logic       write_wen;
  logic       write_thread;
  iqe_wcnt_t  write_cnt;
  iqe_wcnt_t  write_start;
  iqe_extra_t write_data0;
  iqe_extra_t write_data1;
  iqe_extra_t write_data2;
  iqe_extra_t write_data3;
  logic       fetch_stall;
  logic       full;
  logic       stall;
  logic       read_thread;
  iqe_rcnt_t  read_cnt;
  iqe_extra_t read_data0;
  iqe_extra_t read_data1;
  logic       except;
  logic       except_thread;

  // Case list, one entry per line of the file.
  string case_op [$];
  int    case_thr [$];
  int    case_wcnt [$];
  int    case_wstart [$];
  int    case_rthr [$];
  int    case_rcnt [$];
  int    case_fstall [$];
  int    case_stall [$];

  // Reference queues, oldest word at the front.
  iqe_extra_t model_q0 [$];
  iqe_extra_t model_q1 [$];

  iqe_extra_t lane_words [4];
  logic [31:0] rng_state = 32'h6302eab6;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  // Words the DUT presented at the last accepted read.
  iqe_extra_t held_exp0;
  iqe_extra_t held_exp1;
  logic       held_ok0 = 1'b0;
  logic       held_ok1 = 1'b0;
  logic       pend_ok = 1'b0;
  int         pend_case = 0;

  instr_extra_queue u_dut (
    .clk           (clk),
    .rst           (rst),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_cnt     (write_cnt),
    .write_start   (write_start),
    .write_data0   (write_data0),
    .write_data1   (write_data1),
    .write_data2   (write_data2),
    .write_data3   (write_data3),
    .fetch_stall   (fetch_stall),
    .full          (full),
    .stall         (stall),
    .read_thread   (read_thread),
    .read_cnt      (read_cnt),
    .read_data0    (read_data0),
    .read_data1    (read_data1),
    .except        (except),
    .except_thread (except_thread)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Run limit from the number of cases.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the case list did not finish", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------
  // Reference model
  // --------------------

  function automatic int occupancy(input int t);
    return (t == 0) ? model_q0.size() : model_q1.size();
  endfunction

  function automatic iqe_extra_t peek_word(input int t, input int idx);
    return (t == 0) ? model_q0[idx] : model_q1[idx];
  endfunction

  task automatic push_word(input int t, input iqe_extra_t w);
    if (t == 0) model_q0.push_back(w);
    else model_q1.push_back(w);
  endtask

  task automatic drop_word(input int t);
    if (t == 0) void'(model_q0.pop_front());
    else void'(model_q1.pop_front());
  endtask

  task automatic flush_thread(input int t);
    if (t == 0) model_q0.delete();
    else model_q1.delete();
  endtask

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_extra(input string name, input iqe_extra_t expected,
                             input iqe_extra_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_full(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Outputs settle after the edge, so they are sampled a half cycle later.
  task automatic check_read_outputs();
    if (pend_ok && held_ok0) begin
      check_extra($sformatf("case %0d read_data0", pend_case), held_exp0, read_data0);
    end
    if (pend_ok && held_ok1) begin
      check_extra($sformatf("case %0d read_data1", pend_case), held_exp1, read_data1);
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    code;
    int    f [7];
    string op;
    string rest;
    fd = $fopen("test/iqe_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file test/iqe_cases.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) break;
      if (op.getc(0) == "#") begin
        code = $fgets(rest, fd);
        continue;
      end
      code = $fscanf(fd, "%d %d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
      if (code != 7) begin
        $display("Case line starting with %s has missing columns", op);
        error_count++;
        break;
      end
      case_op.push_back(op);
      case_thr.push_back(f[0]);
      case_wcnt.push_back(f[1]);
      case_wstart.push_back(f[2]);
      case_rthr.push_back(f[3]);
      case_rcnt.push_back(f[4]);
      case_fstall.push_back(f[5]);
      case_stall.push_back(f[6]);
    end
    $fclose(fd);
  endtask

  task automatic update_model(input int i, input logic do_write, input logic do_except,
                              input logic full_exp);
    int rthr;
    rthr = case_rthr[i];
    if (do_except) begin
      flush_thread(case_thr[i]);
      held_ok0 = 1'b0;
      held_ok1 = 1'b0;
      pend_ok = 1'b0;
      return;
    end
    if (do_write && case_fstall[i] == 0 && !full_exp) begin
      for (int k = 0; k < case_wcnt[i]; k++) begin
        if (case_wstart[i] + k < 4) push_word(case_thr[i], lane_words[case_wstart[i] + k]);
      end
    end
    if (case_stall[i] == 0) begin
      for (int r = 0; r < case_rcnt[i]; r++) begin
        if (occupancy(rthr) == 0) begin
          $display("Case %0d consumes more words than thread %0d holds", i + 1, rthr);
          error_count++;
        end else begin
          drop_word(rthr);
        end
      end
      held_ok0 = occupancy(rthr) >= 1;
      held_ok1 = occupancy(rthr) >= 2;
      if (held_ok0) held_exp0 = peek_word(rthr, 0);
      if (held_ok1) held_exp1 = peek_word(rthr, 1);
    end
    pend_ok = 1'b1;
    pend_case = i + 1;
  endtask

  task automatic apply_case(input int i);
    logic do_write;
    logic do_except;
    logic full_exp;
    @(negedge clk);
    check_read_outputs();
    for (int k = 0; k < 4; k++) begin
      rng_state = xorshift32(rng_state);
      lane_words[k] = iqe_extra_t'(rng_state);
    end
    do_write = (case_op[i] == "write") || (case_op[i] == "both");
    do_except = (case_op[i] == "except");
    if (!do_write && !do_except && case_op[i] != "read" && case_op[i] != "idle") begin
      $display("Case %0d has an unknown opcode %s", i + 1, case_op[i]);
      error_count++;
    end
    write_wen     = do_write;
    write_thread  = 1'(case_thr[i]);
    write_cnt     = iqe_wcnt_t'(case_wcnt[i]);
    write_start   = iqe_wcnt_t'(case_wstart[i]);
    write_data0   = lane_words[0];
    write_data1   = lane_words[1];
    write_data2   = lane_words[2];
    write_data3   = lane_words[3];
    fetch_stall   = 1'(case_fstall[i]);
    stall         = 1'(case_stall[i]);
    read_thread   = 1'(case_rthr[i]);
    read_cnt      = iqe_rcnt_t'(case_rcnt[i]);
    except        = do_except;
    except_thread = 1'(case_thr[i]);
    #1;
    full_exp = occupancy(case_thr[i]) >= `IQE_FULL_LEVEL;
    check_full($sformatf("case %0d full", i + 1), full_exp, full);
    update_model(i, do_write, do_except, full_exp);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rst = 1'b1;
    write_wen = 1'b0;
    write_thread = 1'b0;
    write_cnt = '0;
    write_start = '0;
    write_data0 = '0;
    write_data1 = '0;
    write_data2 = '0;
    write_data3 = '0;
    fetch_stall = 1'b0;
    stall = 1'b1;
    read_thread = 1'b0;
    read_cnt = '0;
    except = 1'b0;
    except_thread = 1'b0;
    load_cases();
    if (case_op.size() == 0) begin
      $display("No cases were loaded");
      error_count++;
    end
    cycle_limit = case_op.size() * 4 + 100;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < case_op.size(); i++) begin
      apply_case(i);
    end
    @(negedge clk);
    check_read_outputs();
    $display("Summary: %0d cases, %0d checks, %0d errors", case_op.size(), check_count,
             error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/instr_extra_queue.sv
// Two-thread instruction extra queue.
// Holds one payload word per queued instruction for each
// hardware thread. Fetch writes up to four words, decode
// reads the two oldest and consumes up to two per cycle.

`timescale 1ns/1ps
`include "iqe_macros.svh"

module instr_extra_queue import iqe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Fetch side.
  input  logic       write_wen,
  input  logic       write_thread,
  input  iqe_wcnt_t  write_cnt,
  input  iqe_wcnt_t  write_start,
  input  iqe_extra_t write_data0,
  input  iqe_extra_t write_data1,
  input  iqe_extra_t write_data2,
  input  iqe_extra_t write_data3,
  input  logic       fetch_stall,
  output logic       full,
  // Decode side.
  input  logic       stall,
  input  logic       read_thread,
  input  iqe_rcnt_t  read_cnt,
  output iqe_extra_t read_data0,
  output iqe_extra_t read_data1,
  // Flush.
  input  logic       except,
  input  logic       except_thread
);

  iqe_ram_if ram_bus ();

  iqe_ptr_ctrl u_ptr_ctrl (
    .clk           (clk),
    .rst           (rst),
    .except        (except),
    .except_thread (except_thread),
    .fetch_stall   (fetch_stall),
    .stall         (stall),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_cnt     (write_cnt),
    .read_thread   (read_thread),
    .read_cnt      (read_cnt),
    .full          (full),
    .ram           (ram_bus)
  );

  iqe_write_align u_write_align (
    .write_start (write_start),
    .write_data0 (write_data0),
    .write_data1 (write_data1),
    .write_data2 (write_data2),
    .write_data3 (write_data3),
    .ram         (ram_bus)
  );

  iqe_ram u_ram (
    .clk        (clk),
    .rst        (rst),
    .ram        (ram_bus),
    .read_data0 (read_data0),
    .read_data1 (read_data1)
  );

  // Aligner and enables agree only if the burst fits the four lanes.
  a_lane_range: assert property (@(posedge clk) disable iff (rst)
    write_wen |-> (int'(write_start) + int'(write_cnt) <= `IQE_WRITE_LANES));

endmodule

//--- logic/iqe_ram.sv
// Instruction extra queue storage.
// 32 entries, two threads of 16, four write ports and two
// read ports. Read address is registered, read data is
// combinational from it, so a write shows up write-first.

`timescale 1ns/1ps
`include "iqe_macros.svh"

module iqe_ram import iqe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  iqe_ram_if.ram     ram,
  output iqe_extra_t read_data0,
  output iqe_extra_t read_data1
);

  localparam int entries = 2 * `IQE_THREAD_DEPTH;

  iqe_extra_t mem [entries];
  iqe_addr_t  rd_addr_q [2];

  // --------------------
  // Write ports
  // --------------------

  always_ff @(posedge clk) begin
    for (int k = 0; k < `IQE_WRITE_LANES; k++) begin
      if (ram.wr_en[k]) begin
        mem[ram.wr_addr[k]] <= ram.wr_data[k];
      end
    end
  end

  // --------------------
  // Read ports
  // --------------------

  // Address held while decode stalls.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q[0] <= '0;
      rd_addr_q[1] <= '0;
    end else if (ram.rd_en) begin
      rd_addr_q[0] <= ram.rd_addr[0];
      rd_addr_q[1] <= ram.rd_addr[1];
    end
  end

  assign read_data0 = mem[rd_addr_q[0]];
  assign read_data1 = mem[rd_addr_q[1]];

  // Tail plus lane offsets never collide within a burst.
  for (genvar i = 0; i < `IQE_WRITE_LANES; i++) begin : g_clash_a
    for (genvar j = i + 1; j < `IQE_WRITE_LANES; j++) begin : g_clash_b
      a_distinct_wr: assert property (@(posedge clk) disable iff (rst)
        (ram.wr_en[i] && ram.wr_en[j]) |-> (ram.wr_addr[i] != ram.wr_addr[j]));
    end
  end

endmodule

//--- logic/iqe_write_align.sv
// Instruction extra queue write aligner.
// Moves the first valid fetch lane onto RAM write port 0
// and the following lanes onto the ports above it.

`timescale 1ns/1ps
`include "iqe_macros.svh"

module iqe_write_align import iqe_pkg::*; (
  input  iqe_wcnt_t  write_start,
  input  iqe_extra_t write_data0,
  input  iqe_extra_t write_data1,
  input  iqe_extra_t write_data2,
  input  iqe_extra_t write_data3,
  iqe_ram_if.align   ram
);

  localparam int lane_bits = $clog2(`IQE_WRITE_LANES);

  iqe_extra_t lanes [`IQE_WRITE_LANES];
  iqe_wcnt_t  src [`IQE_WRITE_LANES];

  assign lanes[0] = write_data0;
  assign lanes[1] = write_data1;
  assign lanes[2] = write_data2;
  assign lanes[3] = write_data3;

  // --------------------
  // Lane shift
  // --------------------

  // Port k takes input lane start plus k.
  // Past the last lane it repeats lane 3, which is never enabled.
  always_comb begin
    for (int k = 0; k < `IQE_WRITE_LANES; k++) begin
      src[k] = write_start + iqe_wcnt_t'(k);
      if (src[k] > iqe_wcnt_t'(`IQE_WRITE_LANES - 1)) begin
        src[k] = iqe_wcnt_t'(`IQE_WRITE_LANES - 1);
      end
      ram.wr_data[k] = lanes[src[k][lane_bits-1:0]];
    end
  end

endmodule

//--- logic/iqe_ptr_ctrl.sv
// Instruction extra queue pointer control.
// Keeps head, tail and occupancy per thread, raises full,
// flushes one thread on an exception and generates the RAM
// addresses and enables for writes and reads.

`timescale 1ns/1ps
`include "iqe_macros.svh"

module iqe_ptr_ctrl import iqe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      except,
  input  logic      except_thread,
  input  logic      fetch_stall,
  input  logic      stall,
  input  logic      write_wen,
  input  logic      write_thread,
  input  iqe_wcnt_t write_cnt,
  input  logic      read_thread,
  input  iqe_rcnt_t read_cnt,
  output logic      full,
  iqe_ram_if.ptr    ram
);

  // Per-thread state.
  iqe_ptr_t   head [2];
  iqe_ptr_t   tail [2];
  iqe_count_t count [2];

  iqe_ptr_t   head_next [2];
  iqe_ptr_t   tail_next [2];
  iqe_count_t count_next [2];
  iqe_wcnt_t  wr_inc [2];
  iqe_rcnt_t  rd_dec [2];

  logic       wr_acc;
  logic       rd_acc;
  iqe_ptr_t   rd_head;

  // --------------------
  // Acceptance
  // --------------------

  // Full looks at the writing thread only.
  assign full   = count[write_thread] >= iqe_count_t'(`IQE_FULL_LEVEL);
  assign wr_acc = write_wen && !fetch_stall && !full && !except;
  assign rd_acc = !stall && !except;

  // Both threads may move in one cycle, or one thread both ways.
  always_comb begin
    for (int t = 0; t < 2; t++) begin
      wr_inc[t]     = (wr_acc && write_thread == 1'(t)) ? write_cnt : '0;
      rd_dec[t]     = (rd_acc && read_thread == 1'(t)) ? read_cnt : '0;
      head_next[t]  = head[t] + iqe_ptr_t'(rd_dec[t]);
      tail_next[t]  = tail[t] + iqe_ptr_t'(wr_inc[t]);
      count_next[t] = count[t] + iqe_count_t'(wr_inc[t]) - iqe_count_t'(rd_dec[t]);
    end
  end

  // --------------------
  // State
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < 2; t++) begin
        head[t]  <= '0;
        tail[t]  <= '0;
        count[t] <= '0;
      end
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (except && except_thread == 1'(t)) begin
          // Flush restarts the thread at entry zero.
          head[t]  <= '0;
          tail[t]  <= '0;
          count[t] <= '0;
        end else begin
          head[t]  <= head_next[t];
          tail[t]  <= tail_next[t];
          count[t] <= count_next[t];
        end
      end
    end
  end

  // --------------------
  // RAM ports
  // --------------------

  // Lane k writes at tail plus k, wrapping inside the thread's half.
  always_comb begin
    for (int k = 0; k < `IQE_WRITE_LANES; k++) begin
      ram.wr_addr[k] = {write_thread, tail[write_thread] + iqe_ptr_t'(k)};
      ram.wr_en[k]   = wr_acc && (iqe_wcnt_t'(k) < write_cnt);
    end
  end

  // Read register takes the head after this cycle's consume.
  assign rd_head     = head_next[read_thread];
  assign ram.rd_addr = {{read_thread, rd_head + iqe_ptr_t'(1)}, {read_thread, rd_head}};
  assign ram.rd_en   = rd_acc;

  // --------------------
  // Checks
  // --------------------

  // The threshold only protects bursts of at most four lanes.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_acc |-> (int'(count[write_thread]) + int'(write_cnt) <= `IQE_THREAD_DEPTH));

  // Decode must not consume words the thread does not hold.
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    rd_acc |-> (iqe_count_t'(read_cnt) <= count[read_thread]));

endmodule

//--- logic/iqe_ram_if.sv
// RAM port bundle for the instruction extra queue.
// Pointer control drives addresses and enables, the aligner drives data.

`timescale 1ns/1ps
`include "iqe_macros.svh"

interface iqe_ram_if import iqe_pkg::*; ();

  // Write side, one entry per lane.
  iqe_addr_t  [`IQE_WRITE_LANES-1:0] wr_addr;
  iqe_extra_t [`IQE_WRITE_LANES-1:0] wr_data;
  logic       [`IQE_WRITE_LANES-1:0] wr_en;

  // Read side, head and head plus one.
  iqe_addr_t  [1:0] rd_addr;
  logic             rd_en;

  modport ptr (
    output wr_addr,
    output wr_en,
    output rd_addr,
    output rd_en
  );

  modport align (
    output wr_data
  );

  modport ram (
    input wr_addr, wr_data, wr_en,
    input rd_addr, rd_en
  );

endinterface

//--- logic/iqe_pkg.sv
// Instruction extra queue types.
// Payload word, RAM address parts, occupancy and burst counts.

`include "iqe_macros.svh"

package iqe_pkg;

  // One extra payload word.
  typedef logic [`IQE_EXTRA_WIDTH-1:0] iqe_extra_t;

  // --------------------
  // Addressing
  // --------------------

  // Pointer inside one thread's half.
  typedef logic [$clog2(`IQE_THREAD_DEPTH)-1:0] iqe_ptr_t;

  // Thread bit on top of the pointer.
  typedef logic [$clog2(`IQE_THREAD_DEPTH):0] iqe_addr_t;

  // Occupancy, 0 to depth inclusive.
  typedef logic [$clog2(`IQE_THREAD_DEPTH):0] iqe_count_t;

  // Write count 0 to 4, also the start lane 0 to 3.
  typedef logic [$clog2(`IQE_WRITE_LANES):0] iqe_wcnt_t;

  // Read count 0 to 2.
  typedef logic [1:0] iqe_rcnt_t;

endpackage

//--- logic/iqe_macros.svh
// Instruction extra queue sizing.
// Shared by the type package and every RTL block of the queue.

`ifndef IQE_MACROS_SVH
`define IQE_MACROS_SVH

// --------------------
// Payload and storage
// --------------------

// Bits of extra payload per queued instruction.
`define IQE_EXTRA_WIDTH 24

// Entries in one thread's half of the RAM.
`define IQE_THREAD_DEPTH 16

// Fetch write ports, one word each.
`define IQE_WRITE_LANES 4

// Occupancy that raises full. Leaves room for one burst.
`define IQE_FULL_LEVEL 13

`endif
